// File: rtl/spif_io_pkg.sv
// SPIF I/O register map with the processor and Wishbone request types
package spif_io_pkg;

  // ==================================================
  // plain vector types
  // ==================================================

  typedef logic [14:0] io_addr_t;    // processor i/o address
  typedef logic [3:0]  reg_sel_t;    // internal register index
  typedef logic [31:0] wb_word_t;    // wishbone data word
  typedef logic [14:0] wb_addr_t;    // wishbone word address
  typedef logic [15:0] code_word_t;  // code ram word

  // ==================================================
  // bundles
  // ==================================================

  // processor request, data travels separately
  typedef struct packed {
    logic     rd;                    // io read strobe
    logic     wr;                    // io write strobe
    io_addr_t addr;                  // mem_addr of the access
  } cpu_io_t;

  // one latched wishbone cycle
  typedef struct packed {
    wb_addr_t addr;                  // adr_o
    wb_word_t data;                  // dat_o
    logic     we;                    // 1 = write
  } wb_req_t;

  // ==================================================
  // register map
  // ==================================================

  // reads and writes decode separately so indices overlap
  localparam reg_sel_t REG_UART      = 4'h0;  // rx byte / tx byte
  localparam reg_sel_t REG_RXFULL    = 4'h1;  // read only
  localparam reg_sel_t REG_TXBUSY    = 4'h2;  // read only
  localparam reg_sel_t REG_CODE_ADDR = 4'h1;  // write only
  localparam reg_sel_t REG_CODE_DATA = 4'h2;  // write only, auto increment
  localparam reg_sel_t REG_CYCLES    = 4'h6;  // free running counter
  localparam reg_sel_t REG_WB_UPPER  = 4'h7;  // upper wishbone bits
  localparam reg_sel_t REG_PRODUCT   = 4'hE;  // product id
  localparam reg_sel_t REG_SIZES     = 4'hF;  // memory size word

  localparam int INTERNAL_LIMIT = 16;  // first wishbone address

endpackage

// File: rtl/uart_esc_pkg.sv
// UART escape coding types and constants shared by the transmit and receive sides
package uart_esc_pkg;

  // ==================================================
  // byte level
  // ==================================================

  typedef logic [7:0] uart_byte_t;  // raw uart byte

  localparam uart_byte_t ESC_BYTE = 8'h10;  // escape marker

  // 0x10..0x13 all share these
  localparam logic [5:0] ESC_PREFIX = ESC_BYTE[7:2];

  // ==================================================
  // receive fsm
  // ==================================================

  typedef enum logic {
    RX_IDLE = 1'b0,  // plain bytes or escape start
    RX_ESC  = 1'b1   // next byte holds the low bits
  } rx_state_e;

endpackage

// File: rtl/uart_esc_tx.sv
// UART transmit escaper sending 0x10..0x13 as a two byte escape pair
`timescale 1ns/100ps

module uart_esc_tx (
  input  logic                     clk,
  input  logic                     arstn,
  input  logic                     i_wr,       // byte accepted from cpu
  input  uart_esc_pkg::uart_byte_t i_byte,     // byte to send
  input  logic                     i_u_ready,  // uart can take a byte
  output logic                     o_u_wr,     // uart transmit strobe
  output uart_esc_pkg::uart_byte_t o_u_dout,   // uart transmit data
  output logic                     o_busy      // write side wait state
);

  import uart_esc_pkg::*;

  logic       escaped;    // second byte still owed
  logic [1:0] lower;      // low bits of escaped byte
  logic       send_low;   // second byte goes out now
  logic       accept;     // new byte taken
  logic       is_esc;     // byte needs escaping

  assign send_low = escaped & i_u_ready & ~o_u_wr;
  assign accept   = i_wr & ~escaped;
  assign is_esc   = (i_byte[7:2] == ESC_PREFIX);
  assign o_busy   = ~i_u_ready | escaped | o_u_wr;  // pulse in flight counts too

  // ==================================================
  // strobe and escape state
  // ==================================================
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      o_u_wr  <= 1'b0;
      escaped <= 1'b0;
    end else begin
      o_u_wr <= 1'b0;               // single cycle strobe
      if (send_low) begin
        o_u_wr  <= 1'b1;
        escaped <= 1'b0;
      end else if (accept) begin
        o_u_wr  <= 1'b1;
        escaped <= is_esc;          // owe the low bits
      end
    end
  end

  // data path
  always_ff @(posedge clk) begin
    if (send_low) begin
      o_u_dout <= {6'b000000, lower};  // 0x00..0x03
    end else if (accept) begin
      lower    <= i_byte[1:0];
      o_u_dout <= is_esc ? ESC_BYTE : i_byte;
    end
  end

endmodule

// File: rtl/uart_esc_rx.sv
// UART receive unescaper feeding a one byte holding register for the processor
`timescale 1ns/100ps

module uart_esc_rx (
  input  logic                     clk,
  input  logic                     arstn,
  input  logic                     i_u_full,  // uart has a byte
  input  uart_esc_pkg::uart_byte_t i_u_din,   // uart received data
  input  logic                     i_take,    // cpu read of the byte
  output logic                     o_u_rd,    // uart consume strobe
  output logic                     o_full,    // holding register valid
  output uart_esc_pkg::uart_byte_t o_byte     // holding register
);

  import uart_esc_pkg::*;

  rx_state_e state;
  logic      rx_ok;       // raw byte available this cycle
  logic      is_esc;      // raw byte is 0x10..0x13

  // skip the cycle right after a pulse, uart full not yet updated
  assign rx_ok  = i_u_full & ~o_u_rd;
  assign is_esc = (i_u_din[7:2] == ESC_PREFIX);

  // ==================================================
  // unescape fsm
  // ==================================================
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      state  <= RX_IDLE;
      o_u_rd <= 1'b0;
      o_full <= 1'b0;
      o_byte <= '0;
    end else begin
      o_u_rd <= 1'b0;
      if (rx_ok) begin
        case (state)
          RX_IDLE: begin
            if (is_esc) begin
              o_u_rd <= 1'b1;                 // escapes never wait
              if (i_u_din[1:0] == 2'b00) begin
                state <= RX_ESC;
              end                             // 0x11..0x13 dropped
            end else if (!o_full) begin
              o_u_rd <= 1'b1;                 // plain byte
              o_byte <= i_u_din;
              o_full <= 1'b1;
            end
          end
          RX_ESC: begin
            if (!o_full) begin                // else stall the uart
              o_u_rd <= 1'b1;
              o_byte <= {ESC_PREFIX, i_u_din[1:0]};  // restore 0x10+n
              o_full <= 1'b1;
              state  <= RX_IDLE;
            end
          end
          default: begin
            state <= RX_IDLE;
          end
        endcase
      end
      // fill needs empty, clear needs full
      if (i_take && o_full) begin
        o_full <= 1'b0;
      end
    end
  end

endmodule

// File: rtl/wb_master.sv
// Wishbone master carrying one processor access at a time to the external bus
`timescale 1ns/100ps

module wb_master (
  input  logic                  clk,
  input  logic                  arstn,
  input  spif_io_pkg::cpu_io_t  i_req,    // processor strobes and address
  input  spif_io_pkg::wb_word_t i_data,   // upper bits joined with din
  input  logic                  i_ack_i,  // slave acknowledge
  input  spif_io_pkg::wb_word_t i_dat_i,  // slave read data
  output spif_io_pkg::wb_req_t  o_req,    // latched adr, dat, we
  output logic                  o_stb_o,  // strobe, also the busy flag
  output spif_io_pkg::wb_word_t o_rdata   // last read word
);

  import spif_io_pkg::*;

  logic external;   // address past the register block
  logic launch;     // start a bus cycle

  assign external = (i_req.addr >= io_addr_t'(INTERNAL_LIMIT));
  assign launch   = external & (i_req.rd | i_req.wr) & ~o_stb_o;

  // ==================================================
  // bus cycle
  // ==================================================
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      o_stb_o <= 1'b0;
      o_req   <= '0;
      o_rdata <= '0;
    end else if (o_stb_o) begin
      if (i_ack_i) begin                // cycle ends on ack edge
        o_stb_o <= 1'b0;
        if (!o_req.we) begin
          o_rdata <= i_dat_i;           // capture read data
        end
      end
    end else if (launch) begin
      o_stb_o    <= 1'b1;
      o_req.addr <= wb_addr_t'(i_req.addr);
      o_req.data <= i_data;
      o_req.we   <= i_req.wr;           // write wins over read
    end
  end

endmodule

// File: rtl/io_regs.sv
// SPIF register block with read mux, counter, code RAM loader, wait states and irqs
`timescale 1ns/100ps

module io_regs #(
  parameter int          WIDTH      = 24,     // processor word
  parameter int          CODE_SIZE  = 12,     // log2 code ram words
  parameter logic [15:0] PRODUCT_ID = 16'd1   // product id
) (
  input  logic                       clk,
  input  logic                       arstn,
  input  spif_io_pkg::cpu_io_t       i_io,        // processor request
  input  logic [WIDTH-1:0]           i_din,       // processor write data
  input  logic                       i_rx_full,   // holding register valid
  input  uart_esc_pkg::uart_byte_t   i_rx_byte,   // received byte
  input  logic                       i_tx_busy,   // escaper busy
  input  logic                       i_wb_busy,   // wishbone strobe up
  input  spif_io_pkg::wb_word_t      i_wb_rdata,  // last wishbone read
  input  spif_io_pkg::io_addr_t      i_code_addr, // instruction fetch address
  output logic [WIDTH-1:0]           o_io_dout,   // read data
  output logic                       o_hold,      // processor wait state
  output logic                       o_tx_wr,     // byte to escaper
  output uart_esc_pkg::uart_byte_t   o_tx_byte,
  output logic                       o_rx_take,   // empties holding register
  output spif_io_pkg::wb_word_t      o_wb_data,   // outgoing wishbone word
  output logic [CODE_SIZE-1:0]       o_code_a,
  output spif_io_pkg::code_word_t    o_code_din,
  output logic                       o_code_wr,
  output logic                       o_code_rd,
  output logic                       o_cyclev,    // counter wrap strobe
  output logic                       o_urxirq,    // rx full rising
  output logic                       o_utxirq     // tx busy falling
);

  import spif_io_pkg::*;

  localparam logic [3:0] CODE_BITS = 4'(CODE_SIZE);

  logic                 internal;   // register block address
  reg_sel_t             sel;
  logic                 tx_hold;    // uart write back pressure
  logic                 wr_ok;      // write sampled this cycle
  logic                 rd_ok;
  logic [31-WIDTH:0]    wb_upper;   // high bits of outgoing word
  logic [WIDTH-1:0]     cycles;
  logic [WIDTH-1:0]     outword;    // last tx word
  logic [WIDTH-1:0]     reg_dout;
  logic [CODE_SIZE-1:0] code_ptr;   // loader address
  code_word_t           code_data;
  logic                 code_wr_q;  // code ram write cycle
  logic                 rx_full_d;
  logic                 tx_busy_d;

  assign internal = (i_io.addr < io_addr_t'(INTERNAL_LIMIT));
  assign sel      = i_io.addr[3:0];

  // ==================================================
  // wait states and strobes
  // ==================================================
  assign tx_hold   = i_io.wr & internal & (sel == REG_UART) & i_tx_busy;
  assign o_hold    = tx_hold | code_wr_q | i_wb_busy;
  assign wr_ok     = i_io.wr & internal & ~o_hold;
  assign rd_ok     = i_io.rd & internal & ~o_hold;
  assign o_tx_wr   = wr_ok & (sel == REG_UART);
  assign o_tx_byte = i_din[7:0];
  assign o_rx_take = rd_ok & (sel == REG_UART);
  assign o_wb_data = {wb_upper, i_din};

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      {o_cyclev, cycles} <= '0;
      wb_upper  <= '0;
      outword   <= '0;
      code_ptr  <= '0;
      code_wr_q <= 1'b0;
      rx_full_d <= 1'b0;
      tx_busy_d <= 1'b0;
    end else begin
      {o_cyclev, cycles} <= {1'b0, cycles} + 1'b1;  // carry out is the wrap
      rx_full_d <= i_rx_full;
      tx_busy_d <= i_tx_busy;
      code_wr_q <= 1'b0;
      if (code_wr_q) begin
        code_ptr <= code_ptr + 1'b1;  // bump after the write
      end
      if (wr_ok) begin
        case (sel)
          REG_UART:      outword   <= i_din;
          REG_CODE_ADDR: code_ptr  <= i_din[CODE_SIZE-1:0];
          REG_CODE_DATA: code_wr_q <= 1'b1;
          REG_WB_UPPER:  wb_upper  <= i_din[31-WIDTH:0];
          default: ;                        // other slots ignore writes
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_ok && (sel == REG_CODE_DATA)) begin
      code_data <= i_din[15:0];
    end
  end

  // ==================================================
  // read mux
  // ==================================================
  always_comb begin
    case (sel)
      REG_UART:     reg_dout = WIDTH'(i_rx_byte);
      REG_RXFULL:   reg_dout = WIDTH'(i_rx_full);
      REG_TXBUSY:   reg_dout = WIDTH'(i_tx_busy);
      REG_CYCLES:   reg_dout = cycles;
      REG_WB_UPPER: reg_dout = WIDTH'(i_wb_rdata[31:WIDTH]);  // read side high bits
      REG_PRODUCT:  reg_dout = WIDTH'(PRODUCT_ID);
      REG_SIZES:    reg_dout = WIDTH'({CODE_BITS, 8'h00});
      default:      reg_dout = outword;   // unused slots echo tx word
    endcase
  end

  assign o_io_dout = internal ? reg_dout : i_wb_rdata[WIDTH-1:0];

  // code ram port, loader steals it for one cycle
  assign o_code_wr  = code_wr_q;
  assign o_code_rd  = ~code_wr_q;
  assign o_code_a   = code_wr_q ? code_ptr : i_code_addr[CODE_SIZE-1:0];
  assign o_code_din = code_data;

  // interrupt edges
  assign o_urxirq = i_rx_full & ~rx_full_d;
  assign o_utxirq = ~i_tx_busy & tx_busy_d;

endmodule

// File: rtl/spif_top.sv
// SPIF I/O processor top joining registers, UART escaping and the Wishbone bridge
`timescale 1ns/100ps

module spif_top #(
  parameter int          WIDTH      = 24,     // processor word, 17 to 31
  parameter int          CODE_SIZE  = 12,     // log2 code ram words
  parameter logic [15:0] PRODUCT_ID = 16'd1
) (
  input  logic                     clk,
  input  logic                     arstn,
  // ==================================================
  // processor
  input  logic                     i_io_rd,
  input  logic                     i_io_wr,
  input  spif_io_pkg::io_addr_t    i_mem_addr,
  input  logic [WIDTH-1:0]         i_din,
  output logic [WIDTH-1:0]         o_io_dout,
  output logic                     o_hold,
  input  spif_io_pkg::io_addr_t    i_code_addr,  // fetch address
  output logic [CODE_SIZE-1:0]     o_code_a,
  output spif_io_pkg::code_word_t  o_code_din,
  output logic                     o_code_wr,
  output logic                     o_code_rd,
  // ==================================================
  // uart
  input  logic                     i_u_ready,
  output logic                     o_u_wr,
  output uart_esc_pkg::uart_byte_t o_u_dout,
  input  logic                     i_u_full,
  output logic                     o_u_rd,
  input  uart_esc_pkg::uart_byte_t i_u_din,
  // ==================================================
  // wishbone
  output spif_io_pkg::wb_addr_t    o_adr_o,
  output spif_io_pkg::wb_word_t    o_dat_o,
  output logic                     o_we_o,
  output logic                     o_stb_o,
  input  logic                     i_ack_i,
  input  spif_io_pkg::wb_word_t    i_dat_i,
  // interrupts
  output logic                     o_cyclev,
  output logic                     o_urxirq,
  output logic                     o_utxirq
);

  import spif_io_pkg::*;
  import uart_esc_pkg::*;

  cpu_io_t    cpu_io;      // shared by regs and bridge
  wb_req_t    wb_req;
  wb_word_t   wb_data;
  wb_word_t   wb_rdata;
  uart_byte_t tx_byte;
  uart_byte_t rx_byte;
  logic       tx_wr;
  logic       tx_busy;
  logic       rx_take;
  logic       rx_full;

  assign cpu_io  = '{rd: i_io_rd, wr: i_io_wr, addr: i_mem_addr};
  assign o_adr_o = wb_req.addr;
  assign o_dat_o = wb_req.data;
  assign o_we_o  = wb_req.we;

  io_regs #(
    .WIDTH      (WIDTH),
    .CODE_SIZE  (CODE_SIZE),
    .PRODUCT_ID (PRODUCT_ID)
  ) io_regs_i (
    .clk         (clk),
    .arstn       (arstn),
    .i_io        (cpu_io),
    .i_din       (i_din),
    .i_rx_full   (rx_full),
    .i_rx_byte   (rx_byte),
    .i_tx_busy   (tx_busy),
    .i_wb_busy   (o_stb_o),    // strobe up means bus busy
    .i_wb_rdata  (wb_rdata),
    .i_code_addr (i_code_addr),
    .o_io_dout   (o_io_dout),
    .o_hold      (o_hold),
    .o_tx_wr     (tx_wr),
    .o_tx_byte   (tx_byte),
    .o_rx_take   (rx_take),
    .o_wb_data   (wb_data),
    .o_code_a    (o_code_a),
    .o_code_din  (o_code_din),
    .o_code_wr   (o_code_wr),
    .o_code_rd   (o_code_rd),
    .o_cyclev    (o_cyclev),
    .o_urxirq    (o_urxirq),
    .o_utxirq    (o_utxirq)
  );

  uart_esc_tx uart_esc_tx_i (
    .clk       (clk),
    .arstn     (arstn),
    .i_wr      (tx_wr),
    .i_byte    (tx_byte),
    .i_u_ready (i_u_ready),
    .o_u_wr    (o_u_wr),
    .o_u_dout  (o_u_dout),
    .o_busy    (tx_busy)
  );

  uart_esc_rx uart_esc_rx_i (
    .clk      (clk),
    .arstn    (arstn),
    .i_u_full (i_u_full),
    .i_u_din  (i_u_din),
    .i_take   (rx_take),
    .o_u_rd   (o_u_rd),
    .o_full   (rx_full),
    .o_byte   (rx_byte)
  );

  wb_master wb_master_i (
    .clk     (clk),
    .arstn   (arstn),
    .i_req   (cpu_io),
    .i_data  (wb_data),
    .i_ack_i (i_ack_i),
    .i_dat_i (i_dat_i),
    .o_req   (wb_req),
    .o_stb_o (o_stb_o),
    .o_rdata (wb_rdata)
  );

endmodule

// File: bench/tb_spif.sv
// SPIF I/O testbench with UART and Wishbone models, stimulus tables and compare tasks
`timescale 1ns/100ps

module tb_spif;

  import spif_io_pkg::*;
  import uart_esc_pkg::*;

  localparam int WIDTH = 24;
  localparam int CODE_SIZE = 12;
  localparam logic [15:0] PRODUCT_ID = 16'd1;
  localparam int TMO = 400;            // cycles per wait loop

  // ==================================================
  // DUT signals and tables
  // ==================================================
  logic clk, arstn, i_io_rd, i_io_wr, i_u_ready, i_u_full, i_ack_i;
  io_addr_t i_mem_addr, i_code_addr;
  logic [WIDTH-1:0] i_din, o_io_dout;
  logic o_hold, o_code_wr, o_code_rd, o_u_wr, o_u_rd, o_we_o, o_stb_o;
  logic o_cyclev, o_urxirq, o_utxirq;
  logic [CODE_SIZE-1:0] o_code_a;
  code_word_t o_code_din;
  uart_byte_t o_u_dout, i_u_din;
  wb_addr_t o_adr_o;
  wb_word_t o_dat_o, i_dat_i;

  typedef struct packed {
    uart_byte_t b0;
    uart_byte_t b1;
    logic       two;                   // second raw byte present
    logic       valid;                 // a byte comes out
    uart_byte_t exp;
  } rx_row_t;

  typedef struct packed {
    logic [7:0]       upper;
    logic [WIDTH-1:0] din;
    logic             we;
    wb_word_t         rdata;           // slave answer on reads
  } wb_row_t;

  uart_byte_t tx_tab [5] = '{8'h0F, 8'h10, 8'h13, 8'h14, 8'hA5};
  rx_row_t rx_tab [4] = '{
    '{8'h41, 8'h00, 1'b0, 1'b1, 8'h41},
    '{8'h10, 8'h02, 1'b1, 1'b1, 8'h12},
    '{8'h11, 8'h00, 1'b0, 1'b0, 8'h00},
    '{8'h10, 8'h00, 1'b1, 1'b1, 8'h10}};
  wb_row_t wb_tab [4] = '{
    '{8'hA5, 24'h123456, 1'b1, 32'h0},
    '{8'h3C, 24'h000000, 1'b0, 32'hDEADBEEF},
    '{8'h00, 24'hFFFFFF, 1'b1, 32'h0},
    '{8'h7E, 24'h000000, 1'b0, 32'h81C3_5A0F}};
  logic [WIDTH-1:0] code_tab [4] = '{24'hAB1234, 24'h00FFFF, 24'h550001, 24'h0F8000};
  int gap_tab [3] = '{5, 20, 37};

  // model state
  uart_byte_t tx_seen [$];
  uart_byte_t rx_feed [$];
  code_word_t code_addr_seen [$];
  code_word_t code_data_seen [$];
  logic rdy_rand, txirq_seen;
  logic code_rd_in_wr;                 // fetch strobe seen during a loader write
  int rxirq_cnt, ack_wait;
  wb_addr_t last_adr;
  wb_word_t last_dat, slave_rdata;
  logic last_we;

  spif_top #(.WIDTH(WIDTH), .CODE_SIZE(CODE_SIZE), .PRODUCT_ID(PRODUCT_ID)) spif_top_i (
    .clk(clk), .arstn(arstn), .i_io_rd(i_io_rd), .i_io_wr(i_io_wr),
    .i_mem_addr(i_mem_addr), .i_din(i_din), .o_io_dout(o_io_dout), .o_hold(o_hold),
    .i_code_addr(i_code_addr), .o_code_a(o_code_a), .o_code_din(o_code_din),
    .o_code_wr(o_code_wr), .o_code_rd(o_code_rd), .i_u_ready(i_u_ready),
    .o_u_wr(o_u_wr), .o_u_dout(o_u_dout), .i_u_full(i_u_full), .o_u_rd(o_u_rd),
    .i_u_din(i_u_din), .o_adr_o(o_adr_o), .o_dat_o(o_dat_o), .o_we_o(o_we_o),
    .o_stb_o(o_stb_o), .i_ack_i(i_ack_i), .i_dat_i(i_dat_i), .o_cyclev(o_cyclev),
    .o_urxirq(o_urxirq), .o_utxirq(o_utxirq)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;             // 10 ns period
  end

  // ==================================================
  // bus and UART models
  // ==================================================
  always @(posedge clk) begin
    i_u_ready <= rdy_rand ? ($urandom % 4 != 0) : 1'b1;  // ready drops now and then
    if (o_u_wr) tx_seen.push_back(o_u_dout);
    if (o_u_rd && rx_feed.size() > 0) void'(rx_feed.pop_front());
    i_u_full <= (rx_feed.size() > 0);
    i_u_din  <= (rx_feed.size() > 0) ? rx_feed[0] : 8'h00;
    if (o_urxirq) rxirq_cnt++;
    if (o_utxirq) txirq_seen = 1'b1;
    if (o_code_wr) begin
      code_addr_seen.push_back(code_word_t'(o_code_a));
      code_data_seen.push_back(o_code_din);
      if (o_code_rd) code_rd_in_wr = 1'b1;
    end
  end

  // wishbone slave with random ack delay of 0 to 5
  always @(posedge clk) begin
    if (i_ack_i) begin
      i_ack_i <= 1'b0;                 // master drops stb on this edge
    end else if (o_stb_o) begin
      if (ack_wait == 0) begin
        i_ack_i  <= 1'b1;
        i_dat_i  <= slave_rdata;
        last_adr <= o_adr_o;
        last_dat <= o_dat_o;
        last_we  <= o_we_o;
      end else begin
        ack_wait--;
      end
    end else begin
      ack_wait = $urandom % 6;
    end
  end

  // ==================================================
  // checks and processor tasks
  // ==================================================
  task automatic stop_run();
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic fail_with(input string msg);
    $display("%s", msg);
    stop_run();
  endtask

  task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_word(input string name, input wb_word_t got, input wb_word_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_code(input string name, input code_word_t got, input code_word_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  // one processor access repeated while held
  task automatic io_access(input logic wr, input io_addr_t addr, input logic [WIDTH-1:0] data,
                           output logic [WIDTH-1:0] rdata);
    int t;
    @(posedge clk);
    i_io_wr    <= wr;
    i_io_rd    <= ~wr;
    i_mem_addr <= addr;
    i_din      <= data;
    t = 0;
    @(negedge clk);
    while (o_hold) begin
      t++;
      if (t > TMO) fail_with("Timeout: o_hold stayed high during a processor access");
      @(negedge clk);
    end
    rdata = o_io_dout;                 // sampled mid cycle before the accepting edge
    @(posedge clk);
    i_io_wr <= 1'b0;
    i_io_rd <= 1'b0;
    if (addr >= io_addr_t'(INTERNAL_LIMIT)) begin
      t = 0;
      @(negedge clk);
      while (o_stb_o) begin
        t++;
        if (t > TMO) fail_with("Timeout: Wishbone cycle never acknowledged");
        @(negedge clk);
      end
      rdata = o_io_dout;               // captured read word
    end
  endtask

  task automatic io_write(input io_addr_t addr, input logic [WIDTH-1:0] data);
    logic [WIDTH-1:0] dummy;
    io_access(1'b1, addr, data, dummy);
  endtask

  task automatic io_read(input io_addr_t addr, output logic [WIDTH-1:0] data);
    io_access(1'b0, addr, '0, data);
  endtask

  // ==================================================
  // main sequence
  // ==================================================
  initial begin
    logic [WIDTH-1:0] rd, c0;
    logic [8:0] ctl;
    string ctl_names [9];
    uart_byte_t expq [$];
    io_addr_t wa;
    int t, base;
    void'($urandom(32'h6ca8));
    ctl_names = '{"o_u_wr", "o_u_rd", "o_stb_o", "o_we_o", "o_code_wr", "o_hold",
                  "o_urxirq", "o_utxirq", "o_cyclev"};
    arstn = 1'b0;
    i_io_rd = 1'b0;
    i_io_wr = 1'b0;
    i_mem_addr = '0;
    i_din = '0;
    i_code_addr = '0;
    i_u_ready = 1'b1;
    i_u_full = 1'b0;
    i_u_din = '0;
    i_ack_i = 1'b0;
    i_dat_i = '0;
    rdy_rand = 1'b0;
    txirq_seen = 1'b0;
    code_rd_in_wr = 1'b0;
    rxirq_cnt = 0;
    ack_wait = 0;
    slave_rdata = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    ctl = {o_u_wr, o_u_rd, o_stb_o, o_we_o, o_code_wr, o_hold, o_urxirq, o_utxirq, o_cyclev};
    for (int i = 0; i < 9; i++) check_byte(ctl_names[i], uart_byte_t'(ctl[8-i]), 8'h00);
    @(posedge clk);
    arstn <= 1'b1;

    // constant registers
    io_read(io_addr_t'(REG_PRODUCT), rd);
    check_word("REG_PRODUCT", wb_word_t'(rd), wb_word_t'(PRODUCT_ID));
    io_read(io_addr_t'(REG_SIZES), rd);
    check_word("REG_SIZES[11:8]", wb_word_t'(rd[11:8]), wb_word_t'(CODE_SIZE));

    // transmit escaping where 0x10..0x13 go out as 0x10 then 0x0n
    rdy_rand = 1'b1;
    foreach (tx_tab[i]) begin
      if (tx_tab[i] >= 8'h10 && tx_tab[i] <= 8'h13) begin
        expq.push_back(8'h10);
        expq.push_back(tx_tab[i] - 8'h10);
      end else begin
        expq.push_back(tx_tab[i]);
      end
      io_write(io_addr_t'(REG_UART), WIDTH'(tx_tab[i]));
    end
    // last byte is in flight here so busy is high
    @(negedge clk);
    txirq_seen = 1'b0;
    t = 0;
    while (tx_seen.size() < expq.size() || !txirq_seen) begin
      t++;
      if (t > TMO) fail_with("Timeout: UART stream or transmit interrupt missing");
      @(negedge clk);
    end
    rdy_rand = 1'b0;
    check_word("tx byte count", tx_seen.size(), expq.size());
    foreach (expq[i]) check_byte("o_u_dout", tx_seen[i], expq[i]);

    // receive unescaping
    foreach (rx_tab[i]) begin
      base = rxirq_cnt;
      @(negedge clk);
      rx_feed.push_back(rx_tab[i].b0);
      if (rx_tab[i].two) rx_feed.push_back(rx_tab[i].b1);
      if (rx_tab[i].valid) begin
        t = 0;
        rd = '0;
        while (rd[0] !== 1'b1) begin
          t++;
          if (t > TMO) fail_with("Timeout: receive holding register never filled");
          io_read(io_addr_t'(REG_RXFULL), rd);
        end
        io_read(io_addr_t'(REG_UART), rd);
        check_byte("REG_UART", rd[7:0], rx_tab[i].exp);
      end else begin
        t = 0;
        while (rx_feed.size() > 0) begin
          t++;
          if (t > TMO) fail_with("Timeout: discarded escape byte was not consumed");
          @(negedge clk);
        end
        repeat (4) @(negedge clk);
      end
      io_read(io_addr_t'(REG_RXFULL), rd);
      check_word("REG_RXFULL", wb_word_t'(rd), 32'h0);
      check_word("o_urxirq count", rxirq_cnt - base, wb_word_t'(rx_tab[i].valid));
    end

    // wishbone bridge
    foreach (wb_tab[i]) begin
      wa = io_addr_t'(INTERNAL_LIMIT + ($urandom % (32768 - INTERNAL_LIMIT)));
      slave_rdata = wb_tab[i].rdata;
      io_write(io_addr_t'(REG_WB_UPPER), WIDTH'(wb_tab[i].upper));
      if (wb_tab[i].we) begin
        io_write(wa, wb_tab[i].din);
        check_word("o_dat_o", last_dat, {wb_tab[i].upper, wb_tab[i].din});
      end else begin
        io_read(wa, rd);
        check_word("o_io_dout", wb_word_t'(rd), wb_word_t'(wb_tab[i].rdata[WIDTH-1:0]));
        io_read(io_addr_t'(REG_WB_UPPER), rd);
        check_word("REG_WB_UPPER", wb_word_t'(rd), wb_word_t'(wb_tab[i].rdata[31:WIDTH]));
      end
      check_word("o_adr_o", wb_word_t'(last_adr), wb_word_t'(wa));
      check_word("o_we_o", wb_word_t'(last_we), wb_word_t'(wb_tab[i].we));
    end

    // fetch path while the loader is idle
    @(posedge clk);
    i_code_addr <= io_addr_t'(15'h5ABC);
    @(negedge clk);
    check_code("o_code_a", code_word_t'(o_code_a), code_word_t'(12'hABC));
    check_byte("o_code_rd", uart_byte_t'(o_code_rd), 8'h01);

    // code RAM loading from 0x7FE up
    io_write(io_addr_t'(REG_CODE_ADDR), WIDTH'(12'h7FE));
    foreach (code_tab[i]) io_write(io_addr_t'(REG_CODE_DATA), code_tab[i]);
    t = 0;
    while (code_addr_seen.size() < 4) begin
      t++;
      if (t > TMO) fail_with("Timeout: code RAM write pulses missing");
      @(negedge clk);
    end
    foreach (code_tab[i]) begin
      check_code("o_code_a", code_addr_seen[i], code_word_t'(12'h7FE + i));
      check_code("o_code_din", code_data_seen[i], code_tab[i][15:0]);
    end
    check_byte("o_code_rd during o_code_wr", uart_byte_t'(code_rd_in_wr), 8'h00);

    // cycle counter
    foreach (gap_tab[i]) begin
      io_read(io_addr_t'(REG_CYCLES), c0);
      repeat (gap_tab[i]) @(posedge clk);
      io_read(io_addr_t'(REG_CYCLES), rd);
      if (WIDTH'(rd - c0) < WIDTH'(gap_tab[i])) begin
        $display("[ERROR] REG_CYCLES delta got %h expected at least %h", WIDTH'(rd - c0),
                 gap_tab[i]);
        stop_run();
      end
    end

    $display("RESULT: PASS");
    $finish;
  end

  // whole run limit
  initial begin
    #2000000;
    fail_with("Timeout: simulation ran past its time limit");
  end

endmodule

// File: sim.f
rtl/spif_io_pkg.sv
rtl/uart_esc_pkg.sv
rtl/uart_esc_tx.sv
rtl/uart_esc_rx.sv
rtl/wb_master.sv
rtl/io_regs.sv
rtl/spif_top.sv
bench/tb_spif.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the SPIF testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_spif -o tb_spif_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/tb_spif_sim > sim.log 2>&1
rc=$?
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
if [ $rc -ne 0 ]; then
  echo "simulation exited with status $rc"
  exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0
